//--- run.sh
#!/bin/sh
# build the icache testbench with Verilator, run it, and look for the pass line
verilator --binary --timing --assert -j 0 --top-module icache_tb -f verilog.f -o icache_sim \
    && ./obj_dir/icache_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- verification/icache_mem_model.sv
`timescale 1ns/1ps

module icache_mem_model import icache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    // beat requests from the cache
    input  logic                  req_valid_i,
    input  logic [MEM_ADDR_W-1:0] req_addr_i,
    output logic                  req_ready_o,
    // beat responses to the cache
    output logic                  rsp_valid_o,
    output logic [MEM_DATA_W-1:0] rsp_data_o,
    input  logic                  rsp_ready_i
);

// accepted beats wait here in request order
logic [MEM_ADDR_W-1:0] addr_q [$];
int unsigned due_q [$];
int unsigned cycle_cnt;

// four consecutive words, lowest address in the low lane
function automatic logic [MEM_DATA_W-1:0] beat_data(input logic [MEM_ADDR_W-1:0] beat_addr);
    logic [MEM_DATA_W-1:0] d;
    logic [CORE_ADDR_W-1:0] a;
    for (int k = 0; k < 4; k++) begin
        a = {beat_addr, 2'(k)};
        d[k*INST_W +: INST_W] = {16'hc0de, 4'h0, a};
    end
    return d;
endfunction

always @(posedge clk) begin
    if (rst) begin
        addr_q.delete();
        due_q.delete();
        cycle_cnt = 0;
    end else begin
        cycle_cnt = cycle_cnt + 1;
        if (rsp_valid_o && rsp_ready_i) begin
            void'(addr_q.pop_front());
            void'(due_q.pop_front());
        end
        // answer after 0 to 3 extra cycles
        if (req_valid_i && req_ready_o) begin
            addr_q.push_back(req_addr_i);
            due_q.push_back(cycle_cnt + $urandom_range(3));
        end
    end
end

// outputs change on the falling edge only
initial begin
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_data_o = '0;
    forever begin
        @(negedge clk);
        // ready three cycles in four
        req_ready_o = ($urandom_range(3) != 0);
        rsp_valid_o = (addr_q.size() > 0) && (due_q[0] <= cycle_cnt);
        rsp_data_o = (addr_q.size() > 0) ? beat_data(addr_q[0]) : '0;
    end
end

endmodule

//--- verification/icache_tb.sv
`timescale 1ns/1ps

module icache_tb import icache_pkg::*; ();

localparam int unsigned CLK_PERIOD = 100;
localparam int unsigned SEED = 11647;
localparam int unsigned STREAM_LEN = 300;
// about 300 requests at up to 12 cycles each
localparam int unsigned TIMEOUT_CYCLES = 4000;

logic clk;
logic rst;
logic req_core_valid;
logic [CORE_ADDR_W-1:0] req_core_addr;
logic req_core_ready;
logic rsp_core_valid;
logic [INST_W-1:0] rsp_core_data;
logic req_mem_valid;
logic [MEM_ADDR_W-1:0] req_mem_addr;
logic req_mem_ready;
logic rsp_mem_valid;
logic [MEM_DATA_W-1:0] rsp_mem_data;
logic rsp_mem_ready;

// scoreboard state updated at the rising edge
logic chk_reset;
logic rsp_owed;
logic hit_due;
logic miss_pend;
logic [INST_W-1:0] exp_data;
logic [MEM_ADDR_W-1:0] exp_mem_addr;
int unsigned beat_cnt;
int unsigned last_beats;
int unsigned fire_cnt;
int unsigned rsp_cnt;
int unsigned cycle_cnt = 0;
int unsigned err_cnt = 0;
int unsigned tests_run = 0;
int unsigned tests_failed = 0;

// reference residency and lru
logic [TAG_W-1:0] ref_tag [WAYS][SETS];
logic ref_valid [WAYS][SETS];
logic ref_lru [SETS];

icache_top uut (
    .clk              (clk),
    .rst              (rst),
    .req_core_valid_i (req_core_valid),
    .req_core_addr_i  (req_core_addr),
    .req_core_ready_o (req_core_ready),
    .rsp_core_valid_o (rsp_core_valid),
    .rsp_core_data_o  (rsp_core_data),
    .req_mem_valid_o  (req_mem_valid),
    .req_mem_addr_o   (req_mem_addr),
    .req_mem_ready_i  (req_mem_ready),
    .rsp_mem_valid_i  (rsp_mem_valid),
    .rsp_mem_data_i   (rsp_mem_data),
    .rsp_mem_ready_o  (rsp_mem_ready)
);

icache_mem_model mem_i (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (req_mem_valid),
    .req_addr_i  (req_mem_addr),
    .req_ready_o (req_mem_ready),
    .rsp_valid_o (rsp_mem_valid),
    .rsp_data_o  (rsp_mem_data),
    .rsp_ready_i (rsp_mem_ready)
);

initial begin
    clk = 1'b0;
    forever begin
        #(CLK_PERIOD / 2) clk = ~clk;
    end
end

always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
        $display("timeout after %0d cycles, a request never completed", cycle_cnt);
        $display("SOME TESTS FAILED");
        $finish;
    end
end

//------------------------------------------------------------
// reference model

function automatic logic [INST_W-1:0] predict_word(input logic [CORE_ADDR_W-1:0] a);
    return {16'hc0de, 4'h0, a};
endfunction

// returns 1 on a miss and updates residency and lru
function automatic logic ref_access(input logic [CORE_ADDR_W-1:0] a);
    logic [SET_W-1:0] s;
    logic [TAG_W-1:0] t;
    logic w;
    logic miss;
    s = a[WORD_W +: SET_W];
    t = a[CORE_ADDR_W-1 -: TAG_W];
    miss = 1'b1;
    w = ref_lru[s];
    for (int i = 0; i < WAYS; i++) begin
        if (ref_valid[i][s] && (ref_tag[i][s] == t)) begin
            miss = 1'b0;
            w = 1'(i);
        end
    end
    ref_tag[w][s] = t;
    ref_valid[w][s] = 1'b1;
    ref_lru[s] = ~w;
    return miss;
endfunction

always @(posedge clk) begin
    logic miss;
    if (rst) begin
        for (int s = 0; s < SETS; s++) begin
            ref_lru[s] = 1'b0;
            for (int w = 0; w < WAYS; w++) begin
                ref_valid[w][s] = 1'b0;
            end
        end
        rsp_owed <= 1'b0;
        hit_due <= 1'b0;
        miss_pend <= 1'b0;
        beat_cnt <= 0;
        last_beats <= 0;
        fire_cnt <= 0;
        rsp_cnt <= 0;
    end else begin
        hit_due <= 1'b0;
        if (rsp_core_valid) begin
            rsp_owed <= 1'b0;
            rsp_cnt <= rsp_cnt + 1;
            last_beats <= beat_cnt;
        end
        if (req_mem_valid && req_mem_ready) begin
            beat_cnt <= beat_cnt + 1;
            exp_mem_addr <= exp_mem_addr + 1'b1;
        end
        if (req_core_valid && req_core_ready) begin
            miss = ref_access(req_core_addr);
            rsp_owed <= 1'b1;
            hit_due <= !miss;
            miss_pend <= miss;
            exp_data <= predict_word(req_core_addr);
            // line aligned beat address
            exp_mem_addr <= {req_core_addr[CORE_ADDR_W-1 -: TAG_W + SET_W], 2'b00};
            beat_cnt <= 0;
            fire_cnt <= fire_cnt + 1;
        end
    end
end

//------------------------------------------------------------
// checks

reset_state: assert property (@(posedge clk) disable iff (rst)
    chk_reset |-> (!rsp_core_valid && !req_mem_valid && !rsp_mem_ready && req_core_ready))
    else begin
        $display("t=%0t outputs not idle after reset", $time);
        err_cnt++;
    end

rsp_expected: assert property (@(posedge clk) disable iff (rst) rsp_core_valid |-> rsp_owed)
    else begin
        $display("t=%0t response with no request outstanding", $time);
        err_cnt++;
    end

rsp_word: assert property (@(posedge clk) disable iff (rst)
    (rsp_core_valid && rsp_owed) |-> (rsp_core_data == exp_data))
    else begin
        $display("FAILED t=%0t rsp_core_data_o got %h expected %h",
            $time, rsp_core_data, exp_data);
        err_cnt++;
    end

hit_latency: assert property (@(posedge clk) disable iff (rst) hit_due |-> rsp_core_valid)
    else begin
        $display("t=%0t hit not answered one cycle after acceptance", $time);
        err_cnt++;
    end

mem_on_miss: assert property (@(posedge clk) disable iff (rst)
    req_mem_valid |-> (miss_pend && (beat_cnt < 4)))
    else begin
        $display("t=%0t memory request outside a pending miss", $time);
        err_cnt++;
    end

mem_addr: assert property (@(posedge clk) disable iff (rst)
    (req_mem_valid && miss_pend) |-> (req_mem_addr == exp_mem_addr))
    else begin
        $display("FAILED t=%0t req_mem_addr_o got %h expected %h",
            $time, req_mem_addr, exp_mem_addr);
        err_cnt++;
    end

miss_beats: assert property (@(posedge clk) disable iff (rst)
    (rsp_core_valid && miss_pend) |-> (beat_cnt == 4))
    else begin
        $display("t=%0t miss answered after %0d memory requests", $time, beat_cnt);
        err_cnt++;
    end

//------------------------------------------------------------
// stimulus tasks run from the falling edge

task automatic issue_request(input logic [CORE_ADDR_W-1:0] a);
    int unsigned target;
    target = fire_cnt + 1;
    req_core_valid = 1'b1;
    req_core_addr = a;
    @(negedge clk);
    while (fire_cnt < target) begin
        @(negedge clk);
    end
    req_core_valid = 1'b0;
endtask

task automatic access_and_wait(input logic [CORE_ADDR_W-1:0] a, input logic exp_miss);
    issue_request(a);
    while (rsp_cnt < fire_cnt) begin
        @(negedge clk);
    end
    assert (last_beats == (exp_miss ? 4 : 0))
        else begin
            $display("t=%0t address %h expected %0d memory requests, saw %0d",
                $time, a, exp_miss ? 4 : 0, last_beats);
            err_cnt++;
        end
endtask

task automatic finish_test(input string name, input int unsigned err_start);
    tests_run++;
    if (err_cnt == err_start) begin
        $display("test %0d %s: ok", tests_run, name);
    end else begin
        tests_failed++;
        $display("test %0d %s: %0d errors", tests_run, name, err_cnt - err_start);
    end
endtask

initial begin
    int unsigned err_start;
    void'($urandom(SEED));
    rst = 1'b1;
    req_core_valid = 1'b0;
    req_core_addr = '0;
    chk_reset = 1'b0;
    repeat (5) @(negedge clk);
    rst = 1'b0;

    err_start = err_cnt;
    chk_reset = 1'b1;
    @(negedge clk);
    chk_reset = 1'b0;
    finish_test("reset state", err_start);

    err_start = err_cnt;
    access_and_wait(12'h047, 1'b1);
    finish_test("cold miss", err_start);

    err_start = err_cnt;
    access_and_wait(12'h04c, 1'b0);
    access_and_wait(12'h047, 1'b0);
    finish_test("resident hit", err_start);

    // A, B and C all map to set 2
    err_start = err_cnt;
    access_and_wait(12'h0a3, 1'b1);
    access_and_wait(12'h1a5, 1'b1);
    access_and_wait(12'h0a3, 1'b0);
    access_and_wait(12'h2a9, 1'b1);
    access_and_wait(12'h0a3, 1'b0);
    access_and_wait(12'h1a5, 1'b1);
    finish_test("lru replacement", err_start);

    // four tags per set keep hits and misses mixed
    err_start = err_cnt;
    for (int i = 0; i < STREAM_LEN; i++) begin
        if ($urandom_range(3) == 0) begin
            @(negedge clk);
        end
        issue_request(12'($urandom_range(255)));
    end
    while (rsp_cnt < fire_cnt) begin
        @(negedge clk);
    end
    finish_test("random stream", err_start);

    $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, err_cnt);
    if ((tests_failed == 0) && (err_cnt == 0)) begin
        $display("ALL TESTS PASSED");
    end else begin
        $display("SOME TESTS FAILED");
    end
    $finish;
end

endmodule

//--- verilog.f
verilog/icache_pkg.sv
verilog/icache_lookup.sv
verilog/icache_refill.sv
verilog/icache_data.sv
verilog/icache_top.sv
verification/icache_mem_model.sv
verification/icache_tb.sv

//--- verilog/icache_data.sv
`timescale 1ns/1ps

module icache_data import icache_pkg::*; (
    input  logic                   clk,
    // refill write port
    input  logic                   bank_we_i,
    input  logic                   bank_wr_way_i,
    input  logic [BANK_ADDR_W-1:0] bank_wr_addr_i,
    input  logic [MEM_DATA_W-1:0]  bank_wr_data_i,
    // read port
    input  logic                   rd_way_i,
    input  core_addr_u             rd_addr_i,
    output logic [INST_W-1:0]      rd_data_o
);

//----------------------------------------------------------
// banks

// one beat per entry, SETS x BEATS entries per way
logic [MEM_DATA_W-1:0] bank_q [WAYS][SETS*BEATS];
logic [MEM_DATA_W-1:0] rd_beat_q [WAYS];

logic [BANK_ADDR_W-1:0] rd_bank_addr;
logic rd_way_q;
logic [WORD_IN_BEAT_W-1:0] rd_word_q;

// set and beat sit in the low bits of the beat address
assign rd_bank_addr = rd_addr_i.b.beat_addr[BANK_ADDR_W-1:0];

always_ff @(posedge clk) begin
    for (int w = 0; w < WAYS; w++) begin
        if (bank_we_i && (bank_wr_way_i == 1'(w))) begin
            bank_q[w][bank_wr_addr_i] <= bank_wr_data_i;
        end
        // write-first, the closing beat of a refill
        // may hold the requested word
        if (bank_we_i && (bank_wr_way_i == 1'(w)) && (bank_wr_addr_i == rd_bank_addr)) begin
            rd_beat_q[w] <= bank_wr_data_i;
        end else begin
            rd_beat_q[w] <= bank_q[w][rd_bank_addr];
        end
    end
end

//----------------------------------------------------------
// word select

always_ff @(posedge clk) begin
    rd_way_q <= rd_way_i;
    rd_word_q <= rd_addr_i.b.word_in_beat;
end

assign rd_data_o = rd_beat_q[rd_way_q][rd_word_q*INST_W +: INST_W];

endmodule

//--- verilog/icache_lookup.sv
`timescale 1ns/1ps

module icache_lookup import icache_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    // accepted core request
    input  logic       req_fire_i,
    input  core_addr_u req_addr_i,
    // line fill from refill controller
    input  logic       fill_done_i,
    input  logic       fill_way_i,
    input  core_addr_u fill_addr_i,
    // lookup result
    output logic       hit_o,
    output logic       miss_o,
    output logic       hit_way_o,
    output logic       victim_way_o
);

//----------------------------------------------------------
// arrays

// valid bits per way, one bit per set
logic [SETS-1:0] valid_q [WAYS];
logic [TAG_W-1:0] tag_q [WAYS][SETS];

// one bit per set, names the least recently used way
logic [SETS-1:0] lru_q;

logic [SET_W-1:0] req_set;
logic [TAG_W-1:0] req_tag;
logic [WAYS-1:0] way_match;
logic any_match;

//----------------------------------------------------------
// tag compare

assign req_set = req_addr_i.f.set_idx;
assign req_tag = req_addr_i.f.tag;

always_comb begin
    for (int w = 0; w < WAYS; w++) begin
        way_match[w] = valid_q[w][req_set] && (tag_q[w][req_set] == req_tag);
    end
end

assign any_match = |way_match;

// only meaningful for an accepted request
assign hit_o = req_fire_i && any_match;
assign miss_o = req_fire_i && !any_match;

// two ways, so the upper match bit is the way index
assign hit_way_o = way_match[1];
assign victim_way_o = lru_q[req_set];

//----------------------------------------------------------
// valid and lru update

always_ff @(posedge clk) begin
    if (rst) begin
        for (int w = 0; w < WAYS; w++) begin
            valid_q[w] <= '0;
        end
        lru_q <= '0;
    end else if (fill_done_i) begin
        // line complete, filled way becomes most recent
        valid_q[fill_way_i][fill_addr_i.f.set_idx] <= 1'b1;
        lru_q[fill_addr_i.f.set_idx] <= ~fill_way_i;
    end else if (miss_o) begin
        // victim is dead from the moment it gets chosen
        valid_q[victim_way_o][req_set] <= 1'b0;
    end else if (hit_o) begin
        lru_q[req_set] <= ~hit_way_o;
    end
end

//----------------------------------------------------------
// tag write

always_ff @(posedge clk) begin
    if (fill_done_i) begin
        tag_q[fill_way_i][fill_addr_i.f.set_idx] <= fill_addr_i.f.tag;
    end
end

endmodule

//--- verilog/icache_pkg.sv
package icache_pkg;

//----------------------------------------------------------
// core and memory widths

// core address is a word address
localparam int unsigned CORE_ADDR_W = 12;
localparam int unsigned INST_W = 32;

// one memory beat is a quarter of a line
localparam int unsigned MEM_DATA_W = 128;
localparam int unsigned MEM_ADDR_W = 10;

//----------------------------------------------------------
// cache geometry

localparam int unsigned SETS = 4;
localparam int unsigned WAYS = 2;
localparam int unsigned SET_W = 2;
localparam int unsigned TAG_W = 6;

// 16 words per 64-byte line
localparam int unsigned WORD_W = 4;

// refill beats per line
localparam int unsigned BEATS = 4;
localparam int unsigned BEAT_W = 2;
localparam int unsigned WORD_IN_BEAT_W = 2;

// bank entry is one beat, indexed by set and beat
localparam int unsigned BANK_ADDR_W = 4;

//----------------------------------------------------------
// address views

// fields view for tag lookup
// beat view for refill and word select
// low bits of beat_addr are {set_idx, beat in line}
typedef union packed {
    struct packed {
        logic [TAG_W-1:0] tag;
        logic [SET_W-1:0] set_idx;
        logic [WORD_W-1:0] word;
    } f;
    struct packed {
        logic [MEM_ADDR_W-1:0] beat_addr;
        logic [WORD_IN_BEAT_W-1:0] word_in_beat;
    } b;
} core_addr_u;

//----------------------------------------------------------
// refill controller

typedef enum logic [1:0] {
    IDLE,
    REFILL,
    RESPOND
} refill_state_t;

endpackage

//--- verilog/icache_refill.sv
`timescale 1ns/1ps

module icache_refill import icache_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    // core request
    input  logic                   req_core_valid_i,
    input  core_addr_u             req_core_addr_i,
    output logic                   req_core_ready_o,
    output logic                   req_fire_o,
    // core response
    output logic                   rsp_core_valid_o,
    // lookup result
    input  logic                   hit_i,
    input  logic                   miss_i,
    input  logic                   hit_way_i,
    input  logic                   victim_way_i,
    // memory request
    output logic                   req_mem_valid_o,
    output logic [MEM_ADDR_W-1:0]  req_mem_addr_o,
    input  logic                   req_mem_ready_i,
    // memory response
    input  logic                   rsp_mem_valid_i,
    output logic                   rsp_mem_ready_o,
    // fill update to lookup
    output logic                   fill_done_o,
    output logic                   fill_way_o,
    output core_addr_u             fill_addr_o,
    // data bank control
    output logic                   bank_we_o,
    output logic                   bank_wr_way_o,
    output logic [BANK_ADDR_W-1:0] bank_wr_addr_o,
    output logic                   rd_way_o,
    output core_addr_u             rd_addr_o
);

refill_state_t state_q;
refill_state_t state_d;

// pending miss
core_addr_u pend_addr_q;
logic pend_way_q;

// requests may run ahead of responses
logic [BEAT_W-1:0] issue_cnt_q;
logic issue_done_q;
logic [BEAT_W-1:0] rx_cnt_q;

logic hit_q;
logic req_mem_fire;
logic rsp_mem_fire;
logic last_beat;

//----------------------------------------------------------
// core side

assign req_core_ready_o = (state_q == IDLE);
assign req_fire_o = req_core_valid_i && req_core_ready_o;

// hit answers next cycle, a miss answers from RESPOND
assign rsp_core_valid_o = hit_q || (state_q == RESPOND);

//----------------------------------------------------------
// memory side

assign req_mem_valid_o = (state_q == REFILL) && !issue_done_q;
// line-aligned beat address plus issued beat
assign req_mem_addr_o = {pend_addr_q.f.tag, pend_addr_q.f.set_idx, issue_cnt_q};
assign rsp_mem_ready_o = (state_q == REFILL);

assign req_mem_fire = req_mem_valid_o && req_mem_ready_i;
assign rsp_mem_fire = rsp_mem_valid_i && rsp_mem_ready_o;
assign last_beat = rsp_mem_fire && (rx_cnt_q == BEAT_W'(BEATS - 1));

//----------------------------------------------------------
// fill and bank control

assign fill_done_o = last_beat;
assign fill_way_o = pend_way_q;
assign fill_addr_o = pend_addr_q;

// each beat lands at its set and received-beat slot
assign bank_we_o = rsp_mem_fire;
assign bank_wr_way_o = pend_way_q;
assign bank_wr_addr_o = {pend_addr_q.f.set_idx, rx_cnt_q};

assign rd_way_o = (state_q == IDLE) ? hit_way_i : pend_way_q;
assign rd_addr_o = (state_q == IDLE) ? req_core_addr_i : pend_addr_q;

//----------------------------------------------------------
// state machine

always_comb begin
    state_d = state_q;
    unique case (state_q)
        IDLE: begin
            if (miss_i) begin
                state_d = REFILL;
            end
        end
        REFILL: begin
            if (last_beat) begin
                state_d = RESPOND;
            end
        end
        RESPOND: begin
            state_d = IDLE;
        end
        default: begin
            state_d = IDLE;
        end
    endcase
end

always_ff @(posedge clk) begin
    if (rst) begin
        state_q <= IDLE;
        hit_q <= 1'b0;
        issue_cnt_q <= '0;
        issue_done_q <= 1'b0;
        rx_cnt_q <= '0;
    end else begin
        state_q <= state_d;
        hit_q <= hit_i;
        if (miss_i) begin
            issue_cnt_q <= '0;
            issue_done_q <= 1'b0;
            rx_cnt_q <= '0;
        end else begin
            if (req_mem_fire) begin
                issue_cnt_q <= issue_cnt_q + 1'b1;
                if (issue_cnt_q == BEAT_W'(BEATS - 1)) begin
                    issue_done_q <= 1'b1;
                end
            end
            if (rsp_mem_fire) begin
                rx_cnt_q <= rx_cnt_q + 1'b1;
            end
        end
    end
end

// capture the missed request and its victim
always_ff @(posedge clk) begin
    if (miss_i) begin
        pend_addr_q <= req_core_addr_i;
        pend_way_q <= victim_way_i;
    end
end

endmodule

//--- verilog/icache_top.sv
`timescale 1ns/1ps

module icache_top import icache_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    // core request
    input  logic                   req_core_valid_i,
    input  logic [CORE_ADDR_W-1:0] req_core_addr_i,
    output logic                   req_core_ready_o,
    // core response
    output logic                   rsp_core_valid_o,
    output logic [INST_W-1:0]      rsp_core_data_o,
    // memory request
    output logic                   req_mem_valid_o,
    output logic [MEM_ADDR_W-1:0]  req_mem_addr_o,
    input  logic                   req_mem_ready_i,
    // memory response
    input  logic                   rsp_mem_valid_i,
    input  logic [MEM_DATA_W-1:0]  rsp_mem_data_i,
    output logic                   rsp_mem_ready_o
);

// lookup <-> refill
logic req_fire;
logic hit;
logic miss;
logic hit_way;
logic victim_way;
logic fill_done;
logic fill_way;
core_addr_u fill_addr;

// refill -> data
logic bank_we;
logic bank_wr_way;
logic [BANK_ADDR_W-1:0] bank_wr_addr;
logic rd_way;
core_addr_u rd_addr;

icache_lookup lookup_i (
    .clk          (clk),
    .rst          (rst),
    .req_fire_i   (req_fire),
    .req_addr_i   (req_core_addr_i),
    .fill_done_i  (fill_done),
    .fill_way_i   (fill_way),
    .fill_addr_i  (fill_addr),
    .hit_o        (hit),
    .miss_o       (miss),
    .hit_way_o    (hit_way),
    .victim_way_o (victim_way)
);

icache_refill refill_i (
    .clk              (clk),
    .rst              (rst),
    .req_core_valid_i (req_core_valid_i),
    .req_core_addr_i  (req_core_addr_i),
    .req_core_ready_o (req_core_ready_o),
    .req_fire_o       (req_fire),
    .rsp_core_valid_o (rsp_core_valid_o),
    .hit_i            (hit),
    .miss_i           (miss),
    .hit_way_i        (hit_way),
    .victim_way_i     (victim_way),
    .req_mem_valid_o  (req_mem_valid_o),
    .req_mem_addr_o   (req_mem_addr_o),
    .req_mem_ready_i  (req_mem_ready_i),
    .rsp_mem_valid_i  (rsp_mem_valid_i),
    .rsp_mem_ready_o  (rsp_mem_ready_o),
    .fill_done_o      (fill_done),
    .fill_way_o       (fill_way),
    .fill_addr_o      (fill_addr),
    .bank_we_o        (bank_we),
    .bank_wr_way_o    (bank_wr_way),
    .bank_wr_addr_o   (bank_wr_addr),
    .rd_way_o         (rd_way),
    .rd_addr_o        (rd_addr)
);

icache_data data_i (
    .clk            (clk),
    .bank_we_i      (bank_we),
    .bank_wr_way_i  (bank_wr_way),
    .bank_wr_addr_i (bank_wr_addr),
    .bank_wr_data_i (rsp_mem_data_i),
    .rd_way_i       (rd_way),
    .rd_addr_i      (rd_addr),
    .rd_data_o      (rsp_core_data_o)
);

endmodule
